// File: design/mc_pkg.sv
`default_nettype none

package mc_pkg;

   // ****************************************
   // field widths
   // ****************************************
   localparam int BANK_W    = 3;   // 8 banks
   localparam int ROW_W     = 8;
   localparam int COL_W     = 5;
   localparam int FE_ADDR_W = BANK_W + ROW_W + COL_W;
   localparam int ID_W      = 4;
   localparam int DATA_W    = 32;  // one burst
   localparam int CMD_W     = 3;

   // ****************************************
   // dram command codes
   // ****************************************
   localparam logic [CMD_W-1:0] CMD_NOP = 3'd0;
   localparam logic [CMD_W-1:0] CMD_ACT = 3'd1;
   localparam logic [CMD_W-1:0] CMD_PRE = 3'd2;
   localparam logic [CMD_W-1:0] CMD_RD  = 3'd3;
   localparam logic [CMD_W-1:0] CMD_WR  = 3'd4;

   // frontend address, seen through one of two mappings
   typedef union packed {
      struct packed {
         logic [ROW_W-1:0]  row;   // decoder_type 0
         logic [BANK_W-1:0] bank;
         logic [COL_W-1:0]  col;
      } rbc;
      struct packed {
         logic [BANK_W-1:0] bank;  // decoder_type 1
         logic [ROW_W-1:0]  row;
         logic [COL_W-1:0]  col;
      } brc;
   } fe_addr_u;

endpackage

`default_nettype wire

// File: design/mc_req_if.sv
`timescale 1ns/1ps
`default_nettype none

// one decoded request, decode stage to scheduler
interface mc_req_if import mc_pkg::*; ();

   logic              valid;
   logic              write;
   logic [BANK_W-1:0] bank;
   logic [ROW_W-1:0]  row;
   logic [COL_W-1:0]  col;
   logic [ID_W-1:0]   id;
   logic              ready;   // scheduler idle

   modport decode (
      output valid, write, bank, row, col, id,
      input  ready
   );

   modport sched (
      input  valid, write, bank, row, col, id,
      output ready
   );

endinterface

`default_nettype wire

// File: design/addr_decode.sv
`timescale 1ns/1ps
`default_nettype none

module addr_decode import mc_pkg::*; (
   input  logic            clk,
   input  logic            rst_n,
   input  logic            fe_req_i,
   input  logic            fe_write_i,
   input  fe_addr_u        fe_addr_i,
   input  logic [ID_W-1:0] fe_id_i,
   input  logic            decoder_type_i,
   input  logic            wbuf_full_i,
   output logic            fe_stall_o,
   mc_req_if.decode        req
);

   logic              full_q;
   logic              accept;
   logic [BANK_W-1:0] dec_bank;
   logic [ROW_W-1:0]  dec_row;
   logic [COL_W-1:0]  dec_col;

   // slot frees in the same cycle it hands over to the scheduler
   assign fe_stall_o = (full_q && !req.ready) || wbuf_full_i;
   assign accept     = fe_req_i && !fe_stall_o;
   assign req.valid  = full_q;

   // ****************************************
   // address split
   // ****************************************
   always_comb begin
      if (decoder_type_i) begin
         dec_bank = fe_addr_i.brc.bank;
         dec_row  = fe_addr_i.brc.row;
         dec_col  = fe_addr_i.brc.col;
      end else begin
         dec_bank = fe_addr_i.rbc.bank;
         dec_row  = fe_addr_i.rbc.row;
         dec_col  = fe_addr_i.rbc.col;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         full_q <= 1'b0;
      end else if (accept) begin
         full_q <= 1'b1;
      end else if (req.ready) begin
         full_q <= 1'b0;   // handed over or already empty
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         req.write <= fe_write_i;
         req.bank  <= dec_bank;
         req.row   <= dec_row;
         req.col   <= dec_col;
         req.id    <= fe_id_i;
      end
   end

endmodule

`default_nettype wire

// File: design/cmd_sched.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_sched import mc_pkg::*; #(
   parameter int RCD_CYCLES = 4,
   parameter int RP_CYCLES  = 3
) (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              phy_rdy_i,
   mc_req_if.sched           req,
   output logic              ctrl_valid_o,
   output logic [CMD_W-1:0]  ctrl_cmd_o,
   output logic [BANK_W-1:0] ctrl_bank_o,
   output logic [ROW_W-1:0]  ctrl_addr_o,
   output logic [ID_W-1:0]   ctrl_cas_id_o
);

   localparam int NBANK    = 1 << BANK_W;
   localparam int RCD_WAIT = (RCD_CYCLES > 0) ? RCD_CYCLES - 1 : 0;
   localparam int RP_WAIT  = (RP_CYCLES > 0) ? RP_CYCLES - 1 : 0;
   localparam int WAIT_MAX = (RCD_WAIT > RP_WAIT) ? RCD_WAIT : RP_WAIT;
   localparam int WAIT_W   = $clog2(WAIT_MAX + 2);   // at least one bit

   logic              busy_q;
   logic              write_q;
   logic [BANK_W-1:0] bank_q;
   logic [ROW_W-1:0]  row_q;
   logic [COL_W-1:0]  col_q;
   logic [ID_W-1:0]   id_q;
   logic [WAIT_W-1:0] wait_q;
   logic [NBANK-1:0]  open_q;
   logic [ROW_W-1:0]  open_row_q [NBANK];
   logic              bank_open;
   logic              row_hit;
   logic              issue;
   logic              take;
   logic [CMD_W-1:0]  cmd;

   assign req.ready = !busy_q;
   assign take      = req.valid && !busy_q;

   // ****************************************
   // open-row decision
   // ****************************************
   assign bank_open = open_q[bank_q];
   assign row_hit   = bank_open && (open_row_q[bank_q] == row_q);
   assign issue     = busy_q && phy_rdy_i && (wait_q == '0);

   // PRE and ACT update the table, so the next pick moves on by itself
   always_comb begin
      if (row_hit) begin
         cmd = write_q ? CMD_WR : CMD_RD;
      end else if (bank_open) begin
         cmd = CMD_PRE;   // conflict
      end else begin
         cmd = CMD_ACT;
      end
   end

   assign ctrl_valid_o  = issue;
   assign ctrl_cmd_o    = issue ? cmd : CMD_NOP;
   assign ctrl_bank_o   = bank_q;
   assign ctrl_addr_o   = row_hit ? {{(ROW_W-COL_W){1'b0}}, col_q} : row_q;
   assign ctrl_cas_id_o = id_q;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         busy_q <= 1'b0;
         wait_q <= '0;
         open_q <= '0;   // all banks closed
      end else begin
         if (wait_q != '0) begin
            wait_q <= wait_q - 1'b1;
         end
         if (take) begin
            busy_q <= 1'b1;
         end else if (issue && row_hit) begin
            busy_q <= 1'b0;   // cas ends the request
         end
         if (issue && (cmd == CMD_ACT)) begin
            open_q[bank_q] <= 1'b1;
            wait_q         <= WAIT_W'(RCD_WAIT);
         end
         if (issue && (cmd == CMD_PRE)) begin
            open_q[bank_q] <= 1'b0;
            wait_q         <= WAIT_W'(RP_WAIT);
         end
      end
   end

   // ****************************************
   // request and row storage
   // ****************************************
   always_ff @(posedge clk) begin
      if (take) begin
         write_q <= req.write;
         bank_q  <= req.bank;
         row_q   <= req.row;
         col_q   <= req.col;
         id_q    <= req.id;
      end
      if (issue && (cmd == CMD_ACT)) begin
         open_row_q[bank_q] <= row_q;
      end
   end

endmodule

`default_nettype wire

// File: design/sync_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
   parameter int WIDTH = 32,
   parameter int DEPTH = 8
) (
   input  logic             clk,
   input  logic             rst_n,
   input  logic [WIDTH-1:0] data_i,
   input  logic             valid_i,
   output logic             grant_o,
   output logic [WIDTH-1:0] data_o,
   output logic             valid_o,
   input  logic             grant_i
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   logic [WIDTH-1:0] mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr_q;
   logic [PTR_W-1:0] rd_ptr_q;
   logic [CNT_W-1:0] count_q;
   logic             push;
   logic             pop;

   assign grant_o = (count_q != CNT_W'(DEPTH));   // room left
   assign valid_o = (count_q != '0);
   assign data_o  = mem[rd_ptr_q];
   assign push    = valid_i && grant_o;
   assign pop     = valid_o && grant_i;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (push) begin
            wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
         end
         if (pop) begin
            rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
         end
         if (push && !pop) begin
            count_q <= count_q + 1'b1;
         end else if (pop && !push) begin
            count_q <= count_q - 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr_q] <= data_i;
      end
   end

endmodule

`default_nettype wire

// File: design/ch_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module ch_ctrl import mc_pkg::*; #(
   parameter int RCD_CYCLES = 4,
   parameter int RP_CYCLES  = 3,
   parameter int WBUF_DEPTH = 8,
   parameter int RBUF_DEPTH = 8
) (
   input  logic                 clk,
   input  logic                 rst_n,
   // frontend
   input  logic                 fe_req_i,
   input  logic                 fe_write_i,
   input  logic [FE_ADDR_W-1:0] fe_addr_i,
   input  logic [ID_W-1:0]      fe_id_i,
   input  logic [DATA_W-1:0]    fe_data_i,
   input  logic                 decoder_type_i,
   output logic                 fe_stall_o,
   output logic [DATA_W-1:0]    fe_read_data_o,
   output logic [ID_W-1:0]      fe_read_id_o,
   output logic                 fe_read_valid_o,
   input  logic                 fe_read_grant_i,
   // phy commands
   input  logic                 phy_rdy_i,
   output logic                 ctrl_valid_o,
   output logic [CMD_W-1:0]     ctrl_cmd_o,
   output logic [BANK_W-1:0]    ctrl_bank_o,
   output logic [ROW_W-1:0]     ctrl_addr_o,
   output logic [ID_W-1:0]      ctrl_cas_id_o,
   // phy data buffers
   output logic [DATA_W-1:0]    ctrl_w_data_o,
   output logic                 ctrl_w_valid_o,
   input  logic                 ctrl_w_grant_i,
   input  logic [DATA_W-1:0]    ctrl_r_data_i,
   input  logic [ID_W-1:0]      ctrl_r_id_i,
   input  logic                 ctrl_r_valid_i,
   output logic                 ctrl_r_grant_o
);

   logic wbuf_grant;
   logic wbuf_push;

   mc_req_if req_if ();

   // accepted write strobe
   assign wbuf_push = fe_req_i && !fe_stall_o && fe_write_i;

   // ****************************************
   // decode and execute
   // ****************************************
   addr_decode u_addr_decode (
      .clk            (clk),
      .rst_n          (rst_n),
      .fe_req_i       (fe_req_i),
      .fe_write_i     (fe_write_i),
      .fe_addr_i      (fe_addr_i),
      .fe_id_i        (fe_id_i),
      .decoder_type_i (decoder_type_i),
      .wbuf_full_i    (!wbuf_grant),
      .fe_stall_o     (fe_stall_o),
      .req            (req_if.decode)
   );

   cmd_sched #(
      .RCD_CYCLES (RCD_CYCLES),
      .RP_CYCLES  (RP_CYCLES)
   ) u_cmd_sched (
      .clk           (clk),
      .rst_n         (rst_n),
      .phy_rdy_i     (phy_rdy_i),
      .req           (req_if.sched),
      .ctrl_valid_o  (ctrl_valid_o),
      .ctrl_cmd_o    (ctrl_cmd_o),
      .ctrl_bank_o   (ctrl_bank_o),
      .ctrl_addr_o   (ctrl_addr_o),
      .ctrl_cas_id_o (ctrl_cas_id_o)
   );

   // ****************************************
   // data buffers
   // ****************************************
   sync_fifo #(
      .WIDTH (DATA_W),
      .DEPTH (WBUF_DEPTH)
   ) write_buffer (
      .clk     (clk),
      .rst_n   (rst_n),
      .data_i  (fe_data_i),
      .valid_i (wbuf_push),
      .grant_o (wbuf_grant),
      .data_o  (ctrl_w_data_o),
      .valid_o (ctrl_w_valid_o),
      .grant_i (ctrl_w_grant_i)
   );

   sync_fifo #(
      .WIDTH (DATA_W + ID_W),   // id rides above the data
      .DEPTH (RBUF_DEPTH)
   ) read_buffer (
      .clk     (clk),
      .rst_n   (rst_n),
      .data_i  ({ctrl_r_id_i, ctrl_r_data_i}),
      .valid_i (ctrl_r_valid_i),
      .grant_o (ctrl_r_grant_o),
      .data_o  ({fe_read_id_o, fe_read_data_o}),
      .valid_o (fe_read_valid_o),
      .grant_i (fe_read_grant_i)
   );

endmodule

`default_nettype wire

// File: tests/ch_ctrl_assert.sv
`timescale 1ns/1ps
`default_nettype none

module ch_ctrl_assert import mc_pkg::*; #(
   parameter int RCD_CYCLES = 4,
   parameter int RP_CYCLES  = 3
) (
   input logic              clk,
   input logic              rst_n,
   input logic              phy_rdy_i,
   input logic              ctrl_valid_o,
   input logic [CMD_W-1:0]  ctrl_cmd_o,
   input logic [BANK_W-1:0] ctrl_bank_o
);

   localparam int NBANK   = 1 << BANK_W;
   localparam int RCD_GAP = (RCD_CYCLES > 1) ? RCD_CYCLES - 1 : 0;
   localparam int RP_GAP  = (RP_CYCLES > 1) ? RP_CYCLES - 1 : 0;

   int   rcd_left [NBANK];   // cycles until CAS is legal
   int   rp_left  [NBANK];
   logic cas;

   assign cas = ctrl_valid_o && (ctrl_cmd_o == CMD_RD || ctrl_cmd_o == CMD_WR);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int b = 0; b < NBANK; b++) begin
            rcd_left[b] <= 0;
            rp_left[b]  <= 0;
         end
      end else begin
         for (int b = 0; b < NBANK; b++) begin
            if (ctrl_valid_o && ctrl_cmd_o == CMD_ACT && ctrl_bank_o == BANK_W'(b)) begin
               rcd_left[b] <= RCD_GAP;
            end else if (rcd_left[b] > 0) begin
               rcd_left[b] <= rcd_left[b] - 1;
            end
            if (ctrl_valid_o && ctrl_cmd_o == CMD_PRE && ctrl_bank_o == BANK_W'(b)) begin
               rp_left[b] <= RP_GAP;
            end else if (rp_left[b] > 0) begin
               rp_left[b] <= rp_left[b] - 1;
            end
         end
      end
   end

   act_to_cas: assert property (@(posedge clk) disable iff (!rst_n)
      cas |-> rcd_left[ctrl_bank_o] == 0)
      else $error("CAS to bank %0d before RCD elapsed", ctrl_bank_o);

   pre_to_act: assert property (@(posedge clk) disable iff (!rst_n)
      (ctrl_valid_o && ctrl_cmd_o == CMD_ACT) |-> rp_left[ctrl_bank_o] == 0)
      else $error("ACT to bank %0d before RP elapsed", ctrl_bank_o);

   phy_idle: assert property (@(posedge clk) disable iff (!rst_n)
      !phy_rdy_i |-> !ctrl_valid_o)
      else $error("command issued while phy not ready");

   reset_quiet: assert property (@(posedge clk)
      (!rst_n || $rose(rst_n)) |-> !ctrl_valid_o)
      else $error("command strobe high around reset");

endmodule

bind cmd_sched ch_ctrl_assert #(
   .RCD_CYCLES (RCD_CYCLES),
   .RP_CYCLES  (RP_CYCLES)
) u_sched_assert (
   .clk          (clk),
   .rst_n        (rst_n),
   .phy_rdy_i    (phy_rdy_i),
   .ctrl_valid_o (ctrl_valid_o),
   .ctrl_cmd_o   (ctrl_cmd_o),
   .ctrl_bank_o  (ctrl_bank_o)
);

`default_nettype wire

// File: tests/tb_ch_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ch_ctrl import mc_pkg::*; ();

   localparam int TIMEOUT    = 2000;   // cycles per wait
   localparam int MAX_LINES  = 64;
   localparam int NBANK      = 1 << BANK_W;
   localparam int RBUF_DEPTH = 8;

   typedef struct packed {
      logic              wr;
      logic [BANK_W-1:0] bank;
      logic [ROW_W-1:0]  row;
      logic [COL_W-1:0]  col;
      logic [ID_W-1:0]   id;
      logic [DATA_W-1:0] data;
   } req_t;

   logic                 clk;
   logic                 rst_n;
   logic                 fe_req_i;
   logic                 fe_write_i;
   logic [FE_ADDR_W-1:0] fe_addr_i;
   logic [ID_W-1:0]      fe_id_i;
   logic [DATA_W-1:0]    fe_data_i;
   logic                 decoder_type_i;
   logic                 fe_stall_o;
   logic [DATA_W-1:0]    fe_read_data_o;
   logic [ID_W-1:0]      fe_read_id_o;
   logic                 fe_read_valid_o;
   logic                 fe_read_grant_i;
   logic                 phy_rdy_i;
   logic                 ctrl_valid_o;
   logic [CMD_W-1:0]     ctrl_cmd_o;
   logic [BANK_W-1:0]    ctrl_bank_o;
   logic [ROW_W-1:0]     ctrl_addr_o;
   logic [ID_W-1:0]      ctrl_cas_id_o;
   logic [DATA_W-1:0]    ctrl_w_data_o;
   logic                 ctrl_w_valid_o;
   logic                 ctrl_w_grant_i;
   logic [DATA_W-1:0]    ctrl_r_data_i;
   logic [ID_W-1:0]      ctrl_r_id_i;
   logic                 ctrl_r_valid_i;
   logic                 ctrl_r_grant_o;

   logic [31:0]             tv [0:MAX_LINES*5-1];
   req_t                    req_q [$];    // accepted, CAS not yet seen
   logic [DATA_W-1:0]       wdata_q [$];
   logic [ID_W+DATA_W-1:0]  rret_q [$];   // phy returns waiting for grant
   logic [ID_W+DATA_W-1:0]  rexp_q [$];
   logic [DATA_W-1:0]       phy_mem [logic [FE_ADDR_W-1:0]];
   logic [NBANK-1:0]        open_m;
   logic [ROW_W-1:0]        open_row_m [NBANK];
   logic [31:0]             rng;
   int                      errors;
   int                      checks;
   int                      hold_cnt;
   int                      rbuf_cnt;     // read buffer fill level
   bit                      timed_out;
   bit                      phy_hold;
   bit                      stall_seen;

   ch_ctrl #(
      .RCD_CYCLES (4),
      .RP_CYCLES  (3),
      .WBUF_DEPTH (8),
      .RBUF_DEPTH (RBUF_DEPTH)
   ) UUT (.*);

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic check_eq(input string name, input logic [35:0] got, input logic [35:0] exp);
      checks++;
      assert (got === exp) else begin
         $display("ERROR t=%0t %s got %0h exp %0h", $time, name, got, exp);
         errors++;
      end
   endtask

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // ****************************************
   // phy model and random back-pressure
   // ****************************************
   initial begin
      rng             = 32'hba79_ee73;
      phy_rdy_i       = 1'b0;
      fe_read_grant_i = 1'b0;
      ctrl_w_grant_i  = 1'b0;
      ctrl_r_valid_i  = 1'b0;
      ctrl_r_data_i   = '0;
      ctrl_r_id_i     = '0;
      forever begin
         @(negedge clk);
         rng             = xorshift(rng);
         phy_rdy_i       = !phy_hold && (rng[1:0] != 2'b00);
         fe_read_grant_i = rng[4];
         ctrl_w_grant_i  = rng[7];
         ctrl_r_valid_i  = (rret_q.size() != 0);
         if (rret_q.size() != 0) begin
            {ctrl_r_id_i, ctrl_r_data_i} = rret_q[0];
         end
      end
   end

   // reference model, sampled on the rising edge
   always @(posedge clk) begin
      req_t                   r;
      logic [FE_ADDR_W-1:0]   key;
      logic [DATA_W-1:0]      rdata;
      logic [ID_W+DATA_W-1:0] e;
      if (!rst_n) begin
         open_m   <= '0;
         rbuf_cnt = 0;
      end else begin
         // read buffer takes data while it has room
         check_eq("ctrl_r_grant_o", ctrl_r_grant_o, rbuf_cnt < RBUF_DEPTH);
         if (fe_req_i && !fe_stall_o) begin
            r.wr   = fe_write_i;
            r.col  = fe_addr_i[4:0];
            r.id   = fe_id_i;
            r.data = fe_data_i;
            if (decoder_type_i) begin   // bank on top
               r.bank = fe_addr_i[15:13];
               r.row  = fe_addr_i[12:5];
            end else begin
               r.row  = fe_addr_i[15:8];
               r.bank = fe_addr_i[7:5];
            end
            req_q.push_back(r);
            if (fe_write_i) wdata_q.push_back(fe_data_i);
         end
         if (ctrl_valid_o) begin
            assert (phy_rdy_i) else begin
               $display("command issued at t=%0t while phy_rdy_i was low", $time);
               errors++;
            end
            assert (req_q.size() != 0) else begin
               $display("command issued at t=%0t with no request outstanding", $time);
               errors++;
            end
            if (req_q.size() != 0) begin
               r = req_q[0];
               check_eq("ctrl_bank_o", ctrl_bank_o, r.bank);
               if (open_m[r.bank] && open_row_m[r.bank] == r.row) begin
                  check_eq("ctrl_cmd_o", ctrl_cmd_o, r.wr ? CMD_WR : CMD_RD);
                  check_eq("ctrl_addr_o", ctrl_addr_o, {3'b000, r.col});
                  check_eq("ctrl_cas_id_o", ctrl_cas_id_o, r.id);
                  key = {r.bank, r.row, r.col};
                  if (r.wr) begin
                     phy_mem[key] = r.data;
                  end else begin
                     if (phy_mem.exists(key)) begin
                        rdata = phy_mem[key];
                     end else begin
                        rng   = xorshift(rng);   // never written
                        rdata = rng;
                     end
                     rret_q.push_back({r.id, rdata});
                     rexp_q.push_back({r.id, rdata});
                  end
                  void'(req_q.pop_front());
               end else if (open_m[r.bank]) begin
                  check_eq("ctrl_cmd_o", ctrl_cmd_o, CMD_PRE);   // row conflict
                  open_m[r.bank] <= 1'b0;
               end else begin
                  check_eq("ctrl_cmd_o", ctrl_cmd_o, CMD_ACT);
                  check_eq("ctrl_addr_o", ctrl_addr_o, r.row);
                  open_m[r.bank]     <= 1'b1;
                  open_row_m[r.bank] <= r.row;
               end
            end
         end
         if (ctrl_r_valid_i && rbuf_cnt < RBUF_DEPTH) begin
            void'(rret_q.pop_front());
            rbuf_cnt++;
         end
         if (ctrl_w_valid_o && ctrl_w_grant_i) begin
            assert (wdata_q.size() != 0) else begin
               $display("write data popped at t=%0t with nothing queued", $time);
               errors++;
            end
            if (wdata_q.size() != 0) check_eq("ctrl_w_data_o", ctrl_w_data_o, wdata_q.pop_front());
         end
         if (fe_read_valid_o && fe_read_grant_i) begin
            assert (rexp_q.size() != 0) else begin
               $display("read data returned at t=%0t with no read outstanding", $time);
               errors++;
            end
            if (rbuf_cnt > 0) rbuf_cnt--;
            if (rexp_q.size() != 0) begin
               e = rexp_q.pop_front();
               check_eq("fe_read_data_o", fe_read_data_o, e[DATA_W-1:0]);
               check_eq("fe_read_id_o", fe_read_id_o, e[ID_W+DATA_W-1:DATA_W]);
            end
         end
      end
   end

   // ****************************************
   // request driver and waits
   // ****************************************
   task automatic wait_accept(input int line);
      int n;
      n = 0;
      do begin
         @(posedge clk);
         if (fe_stall_o && phy_hold) begin
            if (!stall_seen) begin
               check_eq("requests held at stall", req_q.size(), 2);
            end
            stall_seen = 1'b1;
            hold_cnt++;
            if (hold_cnt > 4) phy_hold = 1'b0;   // let the pipeline drain
         end
         n++;
      end while (fe_stall_o && n < TIMEOUT);
      if (fe_stall_o) begin
         $display("timeout: request on line %0d was never accepted", line);
         timed_out = 1'b1;
      end
   endtask

   task automatic drain(input int test);
      int n;
      n = 0;
      do begin
         @(posedge clk);
         phy_hold = 1'b0;
         n++;
      end while ((req_q.size() + wdata_q.size() + rexp_q.size() + rret_q.size()) != 0
                  && n < TIMEOUT);
      if (n >= TIMEOUT) begin
         $display("timeout: test %0d did not complete all requests", test);
         timed_out = 1'b1;
      end
   endtask

   initial begin
      int          i;
      int          nreq;
      int          err_start;
      int          tests;
      int          passed;
      logic [31:0] mode;
      i              = 0;
      tests          = 0;
      passed         = 0;
      rst_n          = 1'b0;
      fe_req_i       = 1'b0;
      fe_write_i     = 1'b0;
      fe_addr_i      = '0;
      fe_id_i        = '0;
      fe_data_i      = '0;
      decoder_type_i = 1'b0;
      $readmemh("tests/ch_ctrl_tests.txt", tv);
      repeat (3) @(posedge clk);
      @(negedge clk);
      check_eq("fe_stall_o", fe_stall_o, 0);
      check_eq("ctrl_valid_o", ctrl_valid_o, 0);
      check_eq("ctrl_w_valid_o", ctrl_w_valid_o, 0);
      check_eq("fe_read_valid_o", fe_read_valid_o, 0);
      rst_n = 1'b1;
      @(posedge clk);
      while (!timed_out && i < MAX_LINES && tv[i*5] != 32'hff) begin
         mode       = tv[i*5];
         err_start  = errors;
         nreq       = 0;
         stall_seen = 1'b0;
         hold_cnt   = 0;
         phy_hold   = mode[1];
         while (!timed_out && i < MAX_LINES && tv[i*5] == mode) begin
            @(negedge clk);
            fe_req_i       = 1'b1;
            decoder_type_i = mode[0];
            fe_write_i     = tv[i*5+1][0];
            fe_addr_i      = tv[i*5+2][FE_ADDR_W-1:0];
            fe_id_i        = tv[i*5+3][ID_W-1:0];
            fe_data_i      = tv[i*5+4];
            wait_accept(i);
            i++;
            nreq++;
         end
         @(negedge clk);
         fe_req_i = 1'b0;
         if (!timed_out) drain(tests + 1);
         if (mode[1]) begin
            checks++;
            assert (stall_seen) else begin
               $display("test %0d: frontend never stalled with phy_rdy_i held low", tests + 1);
               errors++;
            end
         end
         tests++;
         if (errors == err_start) passed++;
         $display("test %0d mode %0d: %0d requests, %0d errors", tests, mode, nreq,
                  errors - err_start);
      end
      $display("tests %0d passed %0d failed %0d checks %0d errors %0d", tests, passed,
               tests - passed, checks, errors);
      if (errors == 0 && !timed_out) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: tests/ch_ctrl_tests.txt
// mode op addr id data, all hex, one request per line, mode ff ends the list
// mode bit0 picks the address layout, bit1 holds phy_rdy low until the frontend stalls
0 1 1205 1 a0a00001
0 1 1227 2 a0a00002
0 0 1205 3 00000000
0 0 3405 4 00000000
0 1 3410 5 a0a00005
0 0 3410 6 00000000
0 0 1227 7 00000000
0 0 12e7 8 00000000
1 1 2243 9 b1b10009
1 0 2243 a 00000000
1 0 a0c1 b 00000000
1 1 a2c1 c b1b1000c
1 0 a2c1 d 00000000
1 0 a0c1 e 00000000
2 1 5660 1 c2c20001
2 0 5660 2 00000000
2 1 7860 3 c2c20003
2 0 7860 4 00000000
2 0 5660 5 00000000
3 0 2243 6 00000000
3 1 e001 7 d3d30007
3 0 e001 8 00000000
ff 0 0 0 00000000

// File: ch_ctrl.f
design/mc_pkg.sv
design/mc_req_if.sv
design/addr_decode.sv
design/cmd_sched.sv
design/sync_fifo.sv
design/ch_ctrl.sv
tests/ch_ctrl_assert.sv
tests/tb_ch_ctrl.sv

// File: run_sim.sh
#!/bin/sh
# build and run the channel controller testbench, pass only if the log shows the pass line
verilator --binary --timing --assert -Wno-fatal --top-module tb_ch_ctrl \
   -f ch_ctrl.f -Mdir obj_dir > build.log 2>&1 \
   || { echo "build failed, see build.log"; exit 1; }
./obj_dir/Vtb_ch_ctrl > sim.log 2>&1
grep -q '^\*\* PASS \*\*$' sim.log && echo "simulation passed" \
   || { echo "simulation failed, see sim.log"; exit 1; }
